//--- build.f
src/zz_coef_pkg.sv
src/zz_ctrl_pkg.sv
src/zz_ram_wr_if.sv
src/zz_counter.sv
src/zz_ctrl.sv
src/zz_write_path.sv
src/zz_bank_ram.sv
src/zz_read_path.sv
src/zz_top.sv
tests/zz_tb.sv

//--- src/zz_bank_ram.sv
// Two-bank RAM of coefficient pairs with per-lane writes and a registered pair read.
module zz_bank_ram #(
    parameter int COEF_W = 15
) (
    input  logic                     clk,
    zz_ram_wr_if.memory              wr,
    input  logic                     i_rd_en,
    input  logic                     i_rd_bank,
    input  logic [4:0]               i_rd_addr,
    output logic signed [COEF_W-1:0] o_rd_q0,
    output logic signed [COEF_W-1:0] o_rd_q1
);

    localparam int DEPTH = zz_ctrl_pkg::BANK_N * zz_coef_pkg::PAIR_N;

    // Lane 0 holds even scan positions, lane 1 odd ones.
    logic signed [COEF_W-1:0] mem [2][DEPTH];

    logic [5:0] wr_word;
    logic [5:0] rd_word;

    // Bank bit on top of the pair address.
    always_comb begin
        wr_word = {wr.wr_bank, wr.wr_addr};
        rd_word = {i_rd_bank, i_rd_addr};
    end

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 2; lane++) begin
            if (wr.wr_en && wr.wr_lane_en[lane]) begin
                mem[lane][wr_word] <= wr.wr_data;
            end
        end
    end

    // Read data holds when not enabled.
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_q0 <= mem[0][rd_word];
            o_rd_q1 <= mem[1][rd_word];
        end
    end

    // Each coefficient maps to exactly one lane.
    a_lane_onehot: assert property (
        @(posedge clk)
        wr.wr_en |-> $onehot(wr.wr_lane_en)
    );

endmodule

//--- src/zz_coef_pkg.sv
// Block geometry and zigzag scan mapping shared by the write path, the RAM and the control logic.
package zz_coef_pkg;

    // Rows and columns in one block.
    localparam int BLK_N = 8;

    // Coefficient pairs in one block, one pair per RAM word.
    localparam int PAIR_N = BLK_N * BLK_N / 2;

    // Standard JPEG zigzag scan position of a coefficient.
    // Anti-diagonals alternate direction; the upper and lower triangles
    // use mirrored base offsets.
    function automatic logic [5:0] zigzag_pos(
        input logic [2:0] row,
        input logic [2:0] col
    );
        int diag;
        int base;
        int offset;
        diag = int'(row) + int'(col);
        if (diag < BLK_N) begin
            // Upper-left triangle.
            base = diag * (diag + 1) / 2;
            if (diag % 2 == 1) begin
                offset = int'(row);
            end else begin
                offset = int'(col);
            end
        end else begin
            // Lower-right triangle, counted back from the last position.
            base = BLK_N * BLK_N - (2 * BLK_N - 1 - diag) * (2 * BLK_N - diag) / 2;
            if (diag % 2 == 1) begin
                offset = BLK_N - 1 - int'(col);
            end else begin
                offset = BLK_N - 1 - int'(row);
            end
        end
        return 6'(base + offset);
    endfunction

endpackage

//--- src/zz_counter.sv
// Wrapping up-counter with enable, synchronous clear and a terminal-count flag.
module zz_counter #(
    parameter int WIDTH = 3
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             i_en,
    input  logic             i_clr,
    output logic [WIDTH-1:0] o_count,
    output logic             o_last
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_count <= '0;
        end else if (i_clr) begin
            o_count <= '0;
        end else if (i_en) begin
            // Wraps to zero naturally after the maximum.
            o_count <= o_count + 1'b1;
        end
    end

    always_comb begin
        o_last = &o_count;
    end

    // Callers derive clear and enable from disjoint conditions.
    a_en_clr_excl: assert property (
        @(posedge clk) disable iff (!resetn)
        !(i_en && i_clr)
    );

endmodule

//--- src/zz_ctrl.sv
// Bank state machine that hands out the fill bank to the writer and the drain bank to the reader.
module zz_ctrl (
    input  logic       clk,
    input  logic       resetn,
    input  logic       i_wr_fire,
    input  logic       i_col_last,
    input  logic [2:0] i_row_idx,
    input  logic       i_rd_done,
    output logic       o_wr_ok,
    output logic       o_wr_bank,
    output logic       o_rd_ok,
    output logic       o_rd_bank
);

    zz_ctrl_pkg::bank_state_t bank_state [zz_ctrl_pkg::BANK_N];

    // One pointer bit selects between the two banks.
    logic wr_ptr;
    logic rd_ptr;
    logic blk_end;

    // Last column of the last row closes the block.
    always_comb begin
        blk_end = i_wr_fire && i_col_last && (i_row_idx == 3'(zz_coef_pkg::BLK_N - 1));
    end

    always_comb begin
        o_wr_ok = (bank_state[wr_ptr] == zz_ctrl_pkg::BANK_EMPTY) ||
                  (bank_state[wr_ptr] == zz_ctrl_pkg::BANK_FILLING);
        o_rd_ok = (bank_state[rd_ptr] == zz_ctrl_pkg::BANK_DRAINING);
        o_wr_bank = wr_ptr;
        o_rd_bank = rd_ptr;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int b = 0; b < zz_ctrl_pkg::BANK_N; b++) begin
                bank_state[b] <= zz_ctrl_pkg::BANK_EMPTY;
            end
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            for (int b = 0; b < zz_ctrl_pkg::BANK_N; b++) begin
                // Writer side.
                if ((int'(wr_ptr) == b) && i_wr_fire) begin
                    if (blk_end) begin
                        bank_state[b] <= zz_ctrl_pkg::BANK_FULL;
                    end else if (bank_state[b] == zz_ctrl_pkg::BANK_EMPTY) begin
                        bank_state[b] <= zz_ctrl_pkg::BANK_FILLING;
                    end
                end
                // Reader side; a full bank starts draining one cycle later.
                if (int'(rd_ptr) == b) begin
                    if (bank_state[b] == zz_ctrl_pkg::BANK_FULL) begin
                        bank_state[b] <= zz_ctrl_pkg::BANK_DRAINING;
                    end else if ((bank_state[b] == zz_ctrl_pkg::BANK_DRAINING) &&
                                 i_rd_done) begin
                        bank_state[b] <= zz_ctrl_pkg::BANK_EMPTY;
                    end
                end
            end
            if (blk_end) begin
                wr_ptr <= ~wr_ptr;
            end
            if (i_rd_done) begin
                rd_ptr <= ~rd_ptr;
            end
        end
    end

    // The writer never lands in the bank that is being drained.
    a_no_fill_drain_overlap: assert property (
        @(posedge clk) disable iff (!resetn)
        (wr_ptr == rd_ptr) |-> !(i_wr_fire && o_rd_ok)
    );

    // The read path only finishes a block that is draining.
    a_done_while_draining: assert property (
        @(posedge clk) disable iff (!resetn)
        i_rd_done |-> (bank_state[rd_ptr] == zz_ctrl_pkg::BANK_DRAINING)
    );

endmodule

//--- src/zz_ctrl_pkg.sv
// Bank state encoding and bank count for the double-buffer control logic.
package zz_ctrl_pkg;

    // Number of RAM banks in the ping-pong buffer.
    localparam int BANK_N = 2;

    // Life cycle of one bank.
    typedef enum logic [1:0] {
        BANK_EMPTY    = 2'd0,
        BANK_FILLING  = 2'd1,
        BANK_FULL     = 2'd2,
        BANK_DRAINING = 2'd3
    } bank_state_t;

endpackage

//--- src/zz_ram_wr_if.sv
// RAM write port bundle, driven by the write path and received by the bank RAM.
interface zz_ram_wr_if #(
    parameter int COEF_W = 15
);

    logic                     wr_bank;
    logic [4:0]               wr_addr;
    logic signed [COEF_W-1:0] wr_data;
    logic [1:0]               wr_lane_en;
    logic                     wr_en;

    modport writer (
        output wr_bank,
        output wr_addr,
        output wr_data,
        output wr_lane_en,
        output wr_en
    );

    modport memory (
        input wr_bank,
        input wr_addr,
        input wr_data,
        input wr_lane_en,
        input wr_en
    );

endinterface

//--- src/zz_read_path.sv
// Drains a full bank two coefficients per cycle in scan order, honoring output hold.
module zz_read_path #(
    parameter int COEF_W = 15
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     i_rd_ok,
    input  logic                     i_rd_bank,
    input  logic                     i_hold,
    input  logic signed [COEF_W-1:0] i_rd_q0,
    input  logic signed [COEF_W-1:0] i_rd_q1,
    output logic                     o_rd_en,
    output logic [4:0]               o_rd_addr,
    output logic                     o_rd_done,
    output logic                     o_valid,
    output logic [4:0]               o_q_idx,
    output logic signed [COEF_W-1:0] o_q0,
    output logic signed [COEF_W-1:0] o_q1
);

    logic [4:0] pair;
    logic       pair_last;

    always_comb begin
        o_rd_en   = i_rd_ok && !i_hold;
        o_rd_addr = pair;
        o_rd_done = o_rd_en && pair_last;
        o_q0      = i_rd_q0;
        o_q1      = i_rd_q1;
    end

    // Held at zero whenever no bank is draining.
    zz_counter #(
        .WIDTH (5)
    ) u_pair_cnt (
        .clk     (clk),
        .resetn  (resetn),
        .i_en    (o_rd_en),
        .i_clr   (!i_rd_ok),
        .o_count (pair),
        .o_last  (pair_last)
    );

    // Valid and index line up with the registered RAM data.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_valid <= 1'b0;
            o_q_idx <= 5'd0;
        end else begin
            if (!i_hold) begin
                o_valid <= o_rd_en;
            end
            if (o_rd_en) begin
                o_q_idx <= pair;
            end
        end
    end

    // Output pair and RAM read data stay frozen under hold.
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (o_valid && i_hold) |=> (o_valid && $stable(o_q0) && $stable(o_q1) && $stable(o_q_idx))
    );

    // The drain bank does not switch in the middle of a block.
    a_bank_steady: assert property (
        @(posedge clk) disable iff (!resetn)
        (pair != 5'd0) |-> $stable(i_rd_bank)
    );

endmodule

//--- src/zz_top.sv
// Top level of the coefficient reorder buffer; connects control, write path, RAM and read path.
module zz_top #(
    parameter int COEF_W = 15
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic signed [COEF_W-1:0] i_row [zz_coef_pkg::BLK_N],
    input  logic [2:0]               i_row_idx,
    input  logic                     i_valid,
    output logic                     o_hold,
    output logic signed [COEF_W-1:0] o_q0,
    output logic signed [COEF_W-1:0] o_q1,
    output logic [4:0]               o_q_idx,
    output logic                     o_valid,
    input  logic                     i_hold
);

    logic                     wr_ok;
    logic                     wr_bank;
    logic                     wr_fire;
    logic                     col_last;
    logic                     rd_ok;
    logic                     rd_bank;
    logic                     rd_en;
    logic                     rd_done;
    logic [4:0]               rd_addr;
    logic signed [COEF_W-1:0] rd_q0;
    logic signed [COEF_W-1:0] rd_q1;

    zz_ram_wr_if #(
        .COEF_W (COEF_W)
    ) u_wr_if ();

    zz_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .i_wr_fire  (wr_fire),
        .i_col_last (col_last),
        .i_row_idx  (i_row_idx),
        .i_rd_done  (rd_done),
        .o_wr_ok    (wr_ok),
        .o_wr_bank  (wr_bank),
        .o_rd_ok    (rd_ok),
        .o_rd_bank  (rd_bank)
    );

    zz_write_path #(
        .COEF_W (COEF_W)
    ) u_write (
        .clk        (clk),
        .resetn     (resetn),
        .i_row      (i_row),
        .i_row_idx  (i_row_idx),
        .i_valid    (i_valid),
        .i_wr_ok    (wr_ok),
        .i_wr_bank  (wr_bank),
        .o_hold     (o_hold),
        .o_wr_fire  (wr_fire),
        .o_col_last (col_last),
        .wr         (u_wr_if.writer)
    );

    zz_bank_ram #(
        .COEF_W (COEF_W)
    ) u_ram (
        .clk       (clk),
        .wr        (u_wr_if.memory),
        .i_rd_en   (rd_en),
        .i_rd_bank (rd_bank),
        .i_rd_addr (rd_addr),
        .o_rd_q0   (rd_q0),
        .o_rd_q1   (rd_q1)
    );

    zz_read_path #(
        .COEF_W (COEF_W)
    ) u_read (
        .clk       (clk),
        .resetn    (resetn),
        .i_rd_ok   (rd_ok),
        .i_rd_bank (rd_bank),
        .i_hold    (i_hold),
        .i_rd_q0   (rd_q0),
        .i_rd_q1   (rd_q1),
        .o_rd_en   (rd_en),
        .o_rd_addr (rd_addr),
        .o_rd_done (rd_done),
        .o_valid   (o_valid),
        .o_q_idx   (o_q_idx),
        .o_q0      (o_q0),
        .o_q1      (o_q1)
    );

endmodule

//--- src/zz_write_path.sv
// Serializes each held input row into single-coefficient writes at zigzag word and lane.
module zz_write_path #(
    parameter int COEF_W = 15
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic signed [COEF_W-1:0] i_row [zz_coef_pkg::BLK_N],
    input  logic [2:0]               i_row_idx,
    input  logic                     i_valid,
    input  logic                     i_wr_ok,
    input  logic                     i_wr_bank,
    output logic                     o_hold,
    output logic                     o_wr_fire,
    output logic                     o_col_last,
    zz_ram_wr_if.writer              wr
);

    logic [2:0] col;
    logic       col_last;
    logic       wr_fire;
    logic       col_clr;
    logic [5:0] pos;

    always_comb begin
        wr_fire = i_valid && i_wr_ok;
        // Restart a row that the source withdrew part way.
        col_clr = !i_valid && (col != 3'd0);
    end

    zz_counter #(
        .WIDTH (3)
    ) u_col_cnt (
        .clk     (clk),
        .resetn  (resetn),
        .i_en    (wr_fire),
        .i_clr   (col_clr),
        .o_count (col),
        .o_last  (col_last)
    );

    always_comb begin
        pos = zz_coef_pkg::zigzag_pos(i_row_idx, col);
    end

    // Even scan positions go to lane 0, odd ones to lane 1.
    always_comb begin
        wr.wr_en      = wr_fire;
        wr.wr_bank    = i_wr_bank;
        wr.wr_addr    = pos[5:1];
        wr.wr_lane_en = pos[0] ? 2'b10 : 2'b01;
        wr.wr_data    = i_row[col];
    end

    // The row is released only with its last column.
    always_comb begin
        o_hold     = !(wr_fire && col_last);
        o_wr_fire  = wr_fire;
        o_col_last = col_last;
    end

endmodule

//--- tests/zz_tb.sv
// Reorder buffer testbench; runs a table of blocks through the DUT and checks the zigzag output.
module zz_tb;

    localparam int COEF_W    = 15;
    localparam int NUM_BLK   = 8;
    localparam int GAP_CYC   = 10;
    localparam int STALL_CYC = 240;
    localparam int WIN_CYC   = 64;
    localparam int WATCHDOG_CYC = NUM_BLK * 64 * 4 + 1000;

    typedef enum {MODE_RAMP, MODE_EXTREME, MODE_RANDOM} data_mode_t;

    typedef struct {
        data_mode_t mode;
        int         hold_pct;
        bit         gap;
    } blk_cfg_t;

    // Hold of 100 means a long output stall at the start of that block.
    blk_cfg_t blk_tbl [NUM_BLK] = '{
        '{MODE_RAMP,    0,   1'b0},
        '{MODE_RAMP,    0,   1'b1},
        '{MODE_RANDOM,  100, 1'b1},
        '{MODE_RANDOM,  0,   1'b0},
        '{MODE_EXTREME, 0,   1'b0},
        '{MODE_RANDOM,  50,  1'b0},
        '{MODE_EXTREME, 30,  1'b1},
        '{MODE_RAMP,    0,   1'b0}
    };

    // Raster index of each zigzag scan position in JPEG order.
    int zz_nat [64] = '{
        0,  1,  8,  16, 9,  2,  3,  10, 17, 24, 32, 25, 18, 11, 4,  5,
        12, 19, 26, 33, 40, 48, 41, 34, 27, 20, 13, 6,  7,  14, 21, 28,
        35, 42, 49, 56, 57, 50, 43, 36, 29, 22, 15, 23, 30, 37, 44, 51,
        58, 59, 52, 45, 38, 31, 39, 46, 53, 60, 61, 54, 47, 55, 62, 63
    };

    logic                     clk;
    logic                     resetn;
    logic signed [COEF_W-1:0] i_row [zz_coef_pkg::BLK_N];
    logic [2:0]               i_row_idx;
    logic                     i_valid;
    logic                     i_hold;
    logic                     o_hold;
    logic signed [COEF_W-1:0] o_q0;
    logic signed [COEF_W-1:0] o_q1;
    logic [4:0]               o_q_idx;
    logic                     o_valid;

    logic signed [COEF_W-1:0] sb_q [$];
    int rows_done;
    int blocks_read;
    int coef_errs;
    int idx_errs;
    int misc_errs;

    zz_top #(
        .COEF_W (COEF_W)
    ) DUT (
        .clk       (clk),
        .resetn    (resetn),
        .i_row     (i_row),
        .i_row_idx (i_row_idx),
        .i_valid   (i_valid),
        .o_hold    (o_hold),
        .o_q0      (o_q0),
        .o_q1      (o_q1),
        .o_q_idx   (o_q_idx),
        .o_valid   (o_valid),
        .i_hold    (i_hold)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic signed [COEF_W-1:0] gen_coef(data_mode_t mode, int b, int n);
        logic signed [COEF_W-1:0] max_v;
        logic signed [COEF_W-1:0] min_v;
        max_v = {1'b0, {(COEF_W-1){1'b1}}};
        min_v = {1'b1, {(COEF_W-1){1'b0}}};
        case (mode)
            MODE_RAMP:    return COEF_W'(b * 64 + n);
            MODE_EXTREME: begin
                // Mix both limits with values near them.
                case (n % 4)
                    0:       return max_v;
                    1:       return min_v;
                    2:       return min_v + COEF_W'(n);
                    default: return max_v - COEF_W'(n);
                endcase
            end
            default:      return COEF_W'($urandom);
        endcase
    endfunction

    task automatic compare_coef(string name, int pair, logic signed [COEF_W-1:0] exp,
                                logic signed [COEF_W-1:0] act);
        if (act !== exp) begin
            coef_errs++;
            $display("FAILED %s pair %0d: expected %h, got %h", name, pair, exp, act);
        end
    endtask

    task automatic verify_idx(string name, logic [4:0] exp, logic [4:0] act);
        if (act !== exp) begin
            idx_errs++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // Sends each block row by row, holding a row until the DUT releases it.
    task automatic send_blocks();
        logic signed [COEF_W-1:0] blk [64];
        for (int b = 0; b < NUM_BLK; b++) begin
            if (blk_tbl[b].gap) begin
                i_valid = 1'b0;
                while (blocks_read < b) begin
                    @(posedge clk);
                end
                repeat (GAP_CYC) @(posedge clk);
                #1;
            end
            for (int n = 0; n < 64; n++) begin
                blk[n] = gen_coef(blk_tbl[b].mode, b, n);
            end
            for (int k = 0; k < 64; k++) begin
                sb_q.push_back(blk[zz_nat[k]]);
            end
            for (int r = 0; r < zz_coef_pkg::BLK_N; r++) begin
                for (int c = 0; c < zz_coef_pkg::BLK_N; c++) begin
                    i_row[c] = blk[r * zz_coef_pkg::BLK_N + c];
                end
                i_row_idx = 3'(r);
                i_valid   = 1'b1;
                @(negedge clk);
                while (o_hold) begin
                    @(negedge clk);
                end
                @(posedge clk);
                rows_done++;
                #1;
            end
        end
        i_valid = 1'b0;
    endtask

    // Drives the output hold and checks every pair taken.
    task automatic drain_blocks();
        int pair;
        int cyc;
        int rows_at_win;
        bit held;
        logic signed [COEF_W-1:0] prev_q0;
        logic signed [COEF_W-1:0] prev_q1;
        logic [4:0]               prev_idx;
        logic signed [COEF_W-1:0] exp0;
        logic signed [COEF_W-1:0] exp1;
        held = 1'b0;
        prev_q0 = '0;
        prev_q1 = '0;
        prev_idx = '0;
        rows_at_win = 0;
        for (int b = 0; b < NUM_BLK; b++) begin
            pair = 0;
            cyc = 0;
            while (pair < zz_coef_pkg::PAIR_N) begin
                @(posedge clk);
                #1;
                if (blk_tbl[b].hold_pct >= 100) begin
                    i_hold = (cyc < STALL_CYC);
                end else begin
                    i_hold = (($urandom % 100) < blk_tbl[b].hold_pct);
                end
                @(negedge clk);
                if (held) begin
                    if (o_valid !== 1'b1) begin
                        misc_errs++;
                        $display("FAILED o_valid under hold: expected %h, got %h", 1'b1, o_valid);
                    end
                    compare_coef("o_q0 under hold", pair, prev_q0, o_q0);
                    compare_coef("o_q1 under hold", pair, prev_q1, o_q1);
                    verify_idx("o_q_idx under hold", prev_idx, o_q_idx);
                end
                // Both banks are full well before the last window of the stall.
                if (blk_tbl[b].hold_pct >= 100) begin
                    if (cyc == STALL_CYC - WIN_CYC) begin
                        rows_at_win = rows_done;
                    end
                    if (cyc == STALL_CYC - 1) begin
                        if (rows_done != rows_at_win || !i_valid) begin
                            misc_errs++;
                            $display("Input was not held off while both banks were full");
                        end
                    end
                end
                if (o_valid && !i_hold) begin
                    if (sb_q.size() < 2) begin
                        misc_errs++;
                        $display("Output pair arrived with no expected data left");
                    end else begin
                        exp0 = sb_q.pop_front();
                        exp1 = sb_q.pop_front();
                        compare_coef("o_q0", pair, exp0, o_q0);
                        compare_coef("o_q1", pair, exp1, o_q1);
                        verify_idx("o_q_idx", 5'(pair), o_q_idx);
                    end
                    pair++;
                end
                held = o_valid && i_hold;
                prev_q0 = o_q0;
                prev_q1 = o_q1;
                prev_idx = o_q_idx;
                cyc++;
            end
            blocks_read++;
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(73));
        resetn = 1'b0;
        i_valid = 1'b0;
        i_row_idx = 3'd0;
        i_hold = 1'b0;
        for (int c = 0; c < zz_coef_pkg::BLK_N; c++) begin
            i_row[c] = '0;
        end
        rows_done = 0;
        blocks_read = 0;
        coef_errs = 0;
        idx_errs = 0;
        misc_errs = 0;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;
        // Idle state before any row arrives.
        repeat (2) @(negedge clk);
        if (o_valid !== 1'b0) begin
            misc_errs++;
            $display("FAILED o_valid after reset: expected %h, got %h", 1'b0, o_valid);
        end
        if (o_hold !== 1'b1) begin
            misc_errs++;
            $display("FAILED o_hold after reset: expected %h, got %h", 1'b1, o_hold);
        end
        @(posedge clk);
        #1;
        fork
            send_blocks();
            drain_blocks();
        join
        if (sb_q.size() != 0) begin
            misc_errs++;
            $display("Expected data left over after the last block: %0d values", sb_q.size());
        end
        $display("Errors: coefficient %0d, index %0d, other %0d", coef_errs, idx_errs, misc_errs);
        if (coef_errs + idx_errs + misc_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
